// File: sim/lsu_assert.sv
/*
 * request stage checks
 * bus stability under back-pressure, reset state and descriptor hold
 */

`default_nettype none

module lsu_assert (
    input  wire logic                   clk_i,
    input  wire logic                   async_rst_n,
    input  wire lsu_op_pkg::lsu_op_t    op_i,
    input  wire lsu_op_pkg::req_state_e state_i,
    input  wire logic                   data_req_i,
    input  wire lsu_op_pkg::mem_req_t   data_i,
    input  wire logic                   gnt_i,
    input  wire logic                   req_busy_i
);

    import lsu_op_pkg::*;

    int unsigned fail_cnt = 0;

    // an ungranted beat keeps its request and payload
    req_held: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        data_req_i && !gnt_i |=> data_req_i && $stable(data_i))
    else begin
        fail_cnt++;
        $error("memory request changed while waiting for a grant");
    end

    req_reset: assert property (@(posedge clk_i)
        !async_rst_n |-> !data_req_i && (state_i == REQ_IDLE))
    else begin
        fail_cnt++;
        $error("request stage active during reset");
    end

    // decode may not replace the descriptor under a running request
    op_held: assert property (@(posedge clk_i) disable iff (!async_rst_n)
        req_busy_i |=> $stable(op_i))
    else begin
        fail_cnt++;
        $error("operation descriptor changed while the request stage was busy");
    end

endmodule

bind lsu_request lsu_assert u_assert (
    .clk_i       (clk_i),
    .async_rst_n (async_rst_n),
    .op_i        (op_i),
    .state_i     (state_q),
    .data_req_i  (data_req_o),
    .data_i      (data_o),
    .gnt_i       (data_gnt_i),
    .req_busy_i  (req_busy_o)
);

`default_nettype wire

// File: sim/tb_clock_gen.sv
/*
 * testbench clock source
 */

`default_nettype none

module tb_clock_gen #(
    parameter int unsigned PERIOD = 4
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_lsu.sv
/*
 * testbench for the vector load/store unit
 * random unit-stride loads and stores against register file and memory models
 */

`default_nettype none

module tb_lsu;

    import lsu_cfg_pkg::*;
    import lsu_op_pkg::*;

    localparam int NUM_OPS   = 200;
    localparam int TIMEOUT   = 200;
    localparam int MEM_BYTES = 2048;

    logic       clk_i;
    logic       async_rst_n;
    logic       op_rdy_i;
    logic       op_store_i;
    eew_e       op_eew_i;
    vl_t        op_vl_i;
    vreg_idx_t  op_vd_i;
    addr_t      op_base_i;
    logic       op_ack_o;
    logic       misaligned_o;
    vreg_idx_t  vreg_rd_addr_o;
    vreg_t      vreg_rd_i     = '0;
    logic       vreg_wr_en_o;
    vreg_idx_t  vreg_wr_addr_o;
    vreg_t      vreg_wr_o;
    vreg_mask_t vreg_wr_mask_o;
    logic       data_req_o;
    mem_req_t   data_o;
    logic       data_gnt_i    = 1'b0;
    logic       data_rvalid_i = 1'b0;
    vmem_t      data_rdata_i  = '0;
    logic       pending_load_o;
    logic       pending_store_o;

    // register file and byte memory models
    vreg_t      rf [32];
    logic [7:0] mem [MEM_BYTES];
    vmem_t      rd_q [$];
    int         rd_wait     = 0;

    // expectations for the operation in flight
    logic       req_allowed = 1'b0;
    logic       cur_store   = 1'b0;
    addr_t      cur_base    = '0;
    vreg_idx_t  cur_vd      = '0;
    int         cur_bytes   = 0;
    vreg_mask_t cur_mask    = '0;
    vreg_t      cur_load    = '0;
    int         beat_idx    = 0;
    int         wr_count    = 0;
    int         rv_cnt      = 0;
    logic       wr_due      = 1'b0;

    // next operation, possibly offered before the current one ends
    logic       nxt_store   = 1'b0;
    eew_e       nxt_eew     = EEW_8;
    vl_t        nxt_vl      = '0;
    vreg_idx_t  nxt_vd      = '0;
    addr_t      nxt_base    = '0;
    logic       nxt_mis     = 1'b0;
    logic       nxt_shown   = 1'b0;

    tb_clock_gen #(.PERIOD(4)) u_clk (.clk_o(clk_i));

    lsu_top u_dut (
        .clk_i           (clk_i),
        .async_rst_n     (async_rst_n),
        .op_rdy_i        (op_rdy_i),
        .op_store_i      (op_store_i),
        .op_eew_i        (op_eew_i),
        .op_vl_i         (op_vl_i),
        .op_vd_i         (op_vd_i),
        .op_base_i       (op_base_i),
        .op_ack_o        (op_ack_o),
        .misaligned_o    (misaligned_o),
        .vreg_rd_addr_o  (vreg_rd_addr_o),
        .vreg_rd_i       (vreg_rd_i),
        .vreg_wr_en_o    (vreg_wr_en_o),
        .vreg_wr_addr_o  (vreg_wr_addr_o),
        .vreg_wr_o       (vreg_wr_o),
        .vreg_wr_mask_o  (vreg_wr_mask_o),
        .data_req_o      (data_req_o),
        .data_o          (data_o),
        .data_gnt_i      (data_gnt_i),
        .data_rvalid_i   (data_rvalid_i),
        .data_rdata_i    (data_rdata_i),
        .pending_load_o  (pending_load_o),
        .pending_store_o (pending_store_o)
    );

    ////////////////////////////////////////////////////////////
    // checking helpers

    task automatic compare(input string name, input logic [VREG_W-1:0] got,
                           input logic [VREG_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("t=%0t %s", $time, why);
        $display("tests failed");
        $fatal(1, "stopping after an error");
    endtask

    // vl elements of the given width, never more than one register
    function automatic int active_bytes(input int vl, input eew_e eew);
        int size;
        case (eew)
            EEW_16:  size = 2;
            EEW_32:  size = 4;
            default: size = 1;
        endcase
        return (vl * size > VREG_BYTES) ? VREG_BYTES : vl * size;
    endfunction

    ////////////////////////////////////////////////////////////
    // memory model with random grants and in-order read data

    always @(posedge clk_i) begin
        vmem_t    word;
        vmem_be_t exp_be;
        int       a;

        data_rvalid_i <= 1'b0;
        if (rd_q.size() > 0) begin
            if (rd_wait == 0) begin
                data_rvalid_i <= 1'b1;
                data_rdata_i  <= rd_q.pop_front();
                rd_wait = $urandom_range(0, 3);
            end else begin
                rd_wait--;
            end
        end
        if (data_req_o && !req_allowed) begin
            abort_run("data_req_o is high while no aligned operation is in progress");
        end
        if (data_req_o && data_gnt_i) begin
            if (beat_idx >= BEATS) begin
                abort_run("more memory beats granted than one register holds");
            end
            a = int'(data_o.addr);
            compare("data_o.addr", data_o.addr, cur_base + addr_t'(beat_idx * VMEM_BYTES));
            compare("data_o.we", data_o.we, cur_store);
            if (cur_store) begin
                for (int j = 0; j < VMEM_BYTES; j++) begin
                    exp_be[j] = (beat_idx * VMEM_BYTES + j) < cur_bytes;
                end
                compare("data_o.be", data_o.be, exp_be);
                compare("data_o.wdata", data_o.wdata, rf[cur_vd][beat_idx * VMEM_W +: VMEM_W]);
                for (int j = 0; j < VMEM_BYTES; j++) begin
                    if (data_o.be[j]) begin
                        mem[a + j] = data_o.wdata[8 * j +: 8];
                    end
                end
            end else begin
                compare("data_o.be", data_o.be, {VMEM_BYTES{1'b1}});
                for (int j = 0; j < VMEM_BYTES; j++) begin
                    word[8 * j +: 8] = mem[a + j];
                end
                rd_q.push_back(word);
            end
            beat_idx++;
        end
        // roughly one stall in three
        data_gnt_i <= ($urandom_range(0, 2) != 0);
    end

    ////////////////////////////////////////////////////////////
    // register file model, registered read port

    always @(posedge clk_i) begin
        vreg_rd_i <= rf[vreg_rd_addr_o];
        // write-back comes exactly one cycle after the last read beat
        compare("vreg_wr_en_o", vreg_wr_en_o, wr_due);
        wr_due = data_rvalid_i && (rv_cnt == BEATS - 1);
        if (data_rvalid_i) begin
            rv_cnt = (rv_cnt + 1) % BEATS;
        end
        if (vreg_wr_en_o) begin
            compare("vreg_wr_addr_o", vreg_wr_addr_o, cur_vd);
            compare("vreg_wr_o", vreg_wr_o, cur_load);
            compare("vreg_wr_mask_o", vreg_wr_mask_o, cur_mask);
            for (int b = 0; b < VREG_BYTES; b++) begin
                if (vreg_wr_mask_o[b]) begin
                    rf[vreg_wr_addr_o][8 * b +: 8] = vreg_wr_o[8 * b +: 8];
                end
            end
            wr_count++;
        end
    end

    // status checks on every cycle
    always @(posedge clk_i) begin
        if (op_ack_o && (pending_load_o || pending_store_o)) begin
            abort_run("op_ack_o was high while an operation was still pending");
        end
        if (misaligned_o && !op_ack_o) begin
            abort_run("misaligned_o was high without op_ack_o");
        end
        if (u_dut.u_request.u_assert.fail_cnt != 0) begin
            abort_run("an assertion in the request stage failed");
        end
    end

    ////////////////////////////////////////////////////////////
    // random operations

    // pick the next operation
    task automatic draw_op();
        nxt_store = 1'($urandom_range(0, 1));
        nxt_eew   = eew_e'($urandom_range(0, 2));
        nxt_vl    = vl_t'($urandom_range(0, 31));
        nxt_vd    = vreg_idx_t'($urandom_range(0, 31));
        nxt_base  = addr_t'($urandom_range(0, 255)) << VMEM_OFF_W;
        nxt_mis   = ($urandom_range(0, 7) == 0);
        if (nxt_mis) begin
            nxt_base = nxt_base + addr_t'($urandom_range(1, VMEM_BYTES - 1));
        end
        nxt_shown = 1'b0;
    endtask

    // put the next operation on the inputs and raise op_rdy_i
    task automatic offer_op();
        op_rdy_i   <= 1'b1;
        op_store_i <= nxt_store;
        op_eew_i   <= nxt_eew;
        op_vl_i    <= nxt_vl;
        op_vd_i    <= nxt_vd;
        op_base_i  <= nxt_base;
        nxt_shown  = 1'b1;
    endtask

    // one operation from acknowledge to completion
    task automatic run_op(input logic more);
        logic       store;
        logic       mis;
        eew_e       eew;
        vl_t        vl;
        vreg_idx_t  vd;
        addr_t      base;
        int         wr_before;
        int         cycles;
        logic [7:0] exp_mem [VREG_BYTES];

        if (!nxt_shown) begin
            repeat ($urandom_range(0, 2)) @(posedge clk_i);
            offer_op();
        end
        store     = nxt_store;
        mis       = nxt_mis;
        eew       = nxt_eew;
        vl        = nxt_vl;
        vd        = nxt_vd;
        base      = nxt_base;
        wr_before = wr_count;

        // the operation may already have waited behind the previous one
        cycles = 0;
        while (!op_ack_o) begin
            @(posedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run("timeout while waiting for op_ack_o");
            end
        end
        op_rdy_i <= 1'b0;
        compare("misaligned_o", misaligned_o, mis);
        if (more) begin
            draw_op();
        end

        // the previous operation is complete here, so the models are current
        cur_store = store;
        cur_base  = base;
        cur_vd    = vd;
        cur_bytes = active_bytes(int'(vl), eew);
        beat_idx  = 0;
        for (int b = 0; b < VREG_BYTES; b++) begin
            cur_mask[b]          = b < cur_bytes;
            cur_load[8 * b +: 8] = mem[int'(base) + b];
            exp_mem[b] = (store && b < cur_bytes) ? rf[vd][8 * b +: 8] : mem[int'(base) + b];
        end

        if (mis) begin
            req_allowed = 1'b0;
            @(posedge clk_i);
            compare("pending_store_o", pending_store_o, 1'b0);
            compare("pending_load_o", pending_load_o, 1'b0);
        end else begin
            req_allowed = 1'b1;
            @(posedge clk_i);
            compare("pending_store_o", pending_store_o, store);
            compare("pending_load_o", pending_load_o, !store);
            // loads request at once, stores wait for the register read
            compare("data_req_o", data_req_o, !store);
            cycles = 0;
            if (store) begin
                compare("vreg_rd_addr_o", vreg_rd_addr_o, vd);
                @(posedge clk_i);
                compare("data_req_o", data_req_o, 1'b1);
                while (pending_store_o) begin
                    compare("pending_load_o", pending_load_o, 1'b0);
                    cycles++;
                    if (cycles > TIMEOUT) begin
                        abort_run("timeout while waiting for a store to finish");
                    end
                    // the next operation may wait while this one is busy
                    if (more && !nxt_shown && ($urandom_range(0, 3) == 0)) begin
                        offer_op();
                    end
                    @(posedge clk_i);
                end
                compare("store beats", beat_idx, BEATS);
                for (int b = 0; b < VREG_BYTES; b++) begin
                    compare($sformatf("mem[%0d]", int'(base) + b), mem[int'(base) + b],
                            exp_mem[b]);
                end
            end else begin
                while (!vreg_wr_en_o) begin
                    compare("pending_load_o", pending_load_o, 1'b1);
                    compare("pending_store_o", pending_store_o, 1'b0);
                    cycles++;
                    if (cycles > TIMEOUT) begin
                        abort_run("timeout while waiting for the load write-back");
                    end
                    if (more && !nxt_shown && ($urandom_range(0, 3) == 0)) begin
                        offer_op();
                    end
                    @(posedge clk_i);
                end
                compare("pending_load_o", pending_load_o, 1'b1);
                @(posedge clk_i);
                compare("pending_load_o", pending_load_o, 1'b0);
                compare("load beats", beat_idx, BEATS);
            end
            req_allowed = 1'b0;
        end
        compare("register writes", wr_count - wr_before, (store || mis) ? 0 : 1);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        async_rst_n = 1'b0;
        op_rdy_i    = 1'b0;
        op_store_i  = 1'b0;
        op_eew_i    = EEW_8;
        op_vl_i     = '0;
        op_vd_i     = '0;
        op_base_i   = '0;
        void'($urandom(32'h780e));
        for (int r = 0; r < 32; r++) begin
            for (int w = 0; w < BEATS; w++) begin
                rf[r][w * VMEM_W +: VMEM_W] = $urandom;
            end
        end
        // byte pattern over all address bits
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'ha5;
        end

        repeat (5) @(posedge clk_i);
        async_rst_n <= 1'b1;
        @(posedge clk_i);
        compare("op_ack_o", op_ack_o, 1'b0);
        compare("data_req_o", data_req_o, 1'b0);
        compare("pending_load_o", pending_load_o, 1'b0);
        compare("pending_store_o", pending_store_o, 1'b0);

        draw_op();
        for (int n = 0; n < NUM_OPS; n++) begin
            run_op(n < NUM_OPS - 1);
        end
        compare("outstanding read beats", rd_q.size(), 0);

        if (u_dut.u_request.u_assert.fail_cnt != 0) begin
            $display("%0d assertion failures in the request stage",
                     u_dut.u_request.u_assert.fail_cnt);
            $display("tests failed");
            $fatal(1, "assertion failures reported");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: src/lsu_cfg_pkg.sv
/*
 * load/store unit configuration
 * data widths, sizes and the vector and memory data types
 */

`default_nettype none

package lsu_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // widths and sizes

    // vector register and memory bus widths in bits
    localparam int unsigned VREG_W = 128;
    localparam int unsigned VMEM_W = 32;

    // same widths counted in bytes
    localparam int unsigned VREG_BYTES = VREG_W / 8;
    localparam int unsigned VMEM_BYTES = VMEM_W / 8;

    // memory beats needed to move one vector register
    localparam int unsigned BEATS = VREG_W / VMEM_W;

    // byte offset bits inside one memory word
    localparam int unsigned VMEM_OFF_W = $clog2(VMEM_BYTES);

    ////////////////////////////////////////////////////////////
    // data types

    typedef logic [VREG_W-1:0]                vreg_t;
    typedef logic [VREG_BYTES-1:0]            vreg_mask_t;
    typedef logic [VMEM_W-1:0]                vmem_t;
    typedef logic [VMEM_BYTES-1:0]            vmem_be_t;
    typedef logic [31:0]                      addr_t;
    typedef logic [4:0]                       vreg_idx_t;
    typedef logic [4:0]                       vl_t;
    // 0 up to VREG_BYTES inclusive
    typedef logic [$clog2(VREG_BYTES+1)-1:0] byte_cnt_t;
    typedef logic [$clog2(BEATS)-1:0]         beat_cnt_t;

endpackage

`default_nettype wire

// File: src/lsu_decode.sv
/*
 * load/store decode stage
 * accepts one operation, checks alignment and holds the descriptor
 */

`default_nettype none

module lsu_decode (
    input  wire logic                   clk_i,
    input  wire logic                   async_rst_n,

    input  wire logic                   op_rdy_i,
    input  wire logic                   op_store_i,
    input  wire lsu_op_pkg::eew_e       op_eew_i,
    input  wire lsu_cfg_pkg::vl_t       op_vl_i,
    input  wire lsu_cfg_pkg::vreg_idx_t op_vd_i,
    input  wire lsu_cfg_pkg::addr_t     op_base_i,
    output logic                        op_ack_o,
    output logic                        misaligned_o,

    input  wire logic                   req_busy_i,
    input  wire logic                   wb_busy_i,
    output logic                        start_o,
    output lsu_op_pkg::lsu_op_t         op_o
);

    import lsu_cfg_pkg::*;
    import lsu_op_pkg::*;

    logic                   aligned;
    logic [$bits(vl_t)+1:0] byte_prod;
    byte_cnt_t              byte_cnt;

    // accept only when request and write-back are both idle
    assign op_ack_o     = op_rdy_i & ~req_busy_i & ~wb_busy_i;
    assign aligned      = (op_base_i[VMEM_OFF_W-1:0] == '0);
    assign misaligned_o = op_ack_o & ~aligned;

    // vl times element size, clipped to one register
    always_comb begin
        case (op_eew_i)
            EEW_16:  byte_prod = {1'b0, op_vl_i, 1'b0};
            EEW_32:  byte_prod = {op_vl_i, 2'b00};
            default: byte_prod = {2'b00, op_vl_i};
        endcase
        if (byte_prod > VREG_BYTES) begin
            byte_cnt = byte_cnt_t'(VREG_BYTES);
        end else begin
            byte_cnt = byte_cnt_t'(byte_prod);
        end
    end

    // misaligned ops are acknowledged but never started
    always_ff @(posedge clk_i or negedge async_rst_n) begin
        if (!async_rst_n) begin
            start_o <= 1'b0;
        end else begin
            start_o <= op_ack_o & aligned;
        end
    end

    always_ff @(posedge clk_i) begin
        if (op_ack_o && aligned) begin
            op_o.store    <= op_store_i;
            op_o.eew      <= op_eew_i;
            op_o.vd       <= op_vd_i;
            op_o.base     <= op_base_i;
            op_o.byte_cnt <= byte_cnt;
        end
    end

endmodule

`default_nettype wire

// File: src/lsu_op_pkg.sv
/*
 * load/store unit operation types
 * operation descriptor, element width, memory request and request FSM state
 */

`default_nettype none

package lsu_op_pkg;

    ////////////////////////////////////////////////////////////
    // operation

    // element width of a unit-stride access
    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } eew_e;

    // descriptor held for the whole operation
    typedef struct packed {
        logic                   store;
        eew_e                   eew;
        lsu_cfg_pkg::vreg_idx_t vd;
        lsu_cfg_pkg::addr_t     base;
        // active bytes of the register, tail excluded
        lsu_cfg_pkg::byte_cnt_t byte_cnt;
    } lsu_op_t;

    ////////////////////////////////////////////////////////////
    // memory side

    // one request beat on the data bus
    typedef struct packed {
        lsu_cfg_pkg::addr_t    addr;
        logic                  we;
        lsu_cfg_pkg::vmem_be_t be;
        lsu_cfg_pkg::vmem_t    wdata;
    } mem_req_t;

    // request stage states
    typedef enum logic [1:0] {
        REQ_IDLE  = 2'd0,
        REQ_FETCH = 2'd1,
        REQ_ISSUE = 2'd2
    } req_state_e;

endpackage

`default_nettype wire

// File: src/lsu_request.sv
/*
 * load/store request stage
 * fetches store data from the register file and issues one memory beat per grant
 */

`default_nettype none

module lsu_request (
    input  wire logic                   clk_i,
    input  wire logic                   async_rst_n,

    input  wire logic                   start_i,
    input  wire lsu_op_pkg::lsu_op_t    op_i,

    output lsu_cfg_pkg::vreg_idx_t      vreg_rd_addr_o,
    input  wire lsu_cfg_pkg::vreg_t     vreg_rd_i,

    output logic                        data_req_o,
    output lsu_op_pkg::mem_req_t        data_o,
    input  wire logic                   data_gnt_i,

    output logic                        req_busy_o
);

    import lsu_cfg_pkg::*;
    import lsu_op_pkg::*;

    req_state_e state_q, state_d;
    beat_cnt_t  cnt_q;
    vreg_t      shift_q;
    logic       granted;
    logic       last_beat;
    vmem_t      store_word;
    vmem_be_t   store_be;

    ////////////////////////////////////////////////////////////
    // request FSM

    // a load issues its first beat already in the start cycle
    assign data_req_o = (state_q != REQ_IDLE) | (start_i & ~op_i.store);
    assign granted    = data_req_o & data_gnt_i;
    assign last_beat  = (cnt_q == beat_cnt_t'(BEATS - 1));
    assign req_busy_o = start_i | (state_q != REQ_IDLE);

    always_comb begin
        case (state_q)
            REQ_IDLE: begin
                state_d = REQ_IDLE;
                if (start_i) begin
                    state_d = op_i.store ? REQ_FETCH : REQ_ISSUE;
                end
            end
            // register data arrives here, first beat goes out directly
            REQ_FETCH: state_d = REQ_ISSUE;
            REQ_ISSUE: state_d = REQ_ISSUE;
            default:   state_d = REQ_IDLE;
        endcase
        if (granted && last_beat) begin
            state_d = REQ_IDLE;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_n) begin
        if (!async_rst_n) begin
            state_q <= REQ_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (granted) begin
                cnt_q <= last_beat ? '0 : cnt_q + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // store data

    // register read is registered, so vd is presented during start
    assign vreg_rd_addr_o = op_i.vd;

    always_ff @(posedge clk_i) begin
        if (state_q == REQ_FETCH) begin
            shift_q <= granted ? (vreg_rd_i >> VMEM_W) : vreg_rd_i;
        end else if (granted) begin
            shift_q <= shift_q >> VMEM_W;
        end
    end

    assign store_word = (state_q == REQ_FETCH) ? vreg_rd_i[VMEM_W-1:0] : shift_q[VMEM_W-1:0];

    // tail bytes beyond byte_cnt are not written
    always_comb begin
        for (int j = 0; j < VMEM_BYTES; j++) begin
            store_be[j] = byte_cnt_t'(cnt_q * VMEM_BYTES + j) < op_i.byte_cnt;
        end
    end

    ////////////////////////////////////////////////////////////
    // memory request

    always_comb begin
        data_o.addr  = op_i.base + (addr_t'(cnt_q) << VMEM_OFF_W);
        data_o.we    = op_i.store;
        data_o.be    = op_i.store ? store_be : '1;
        data_o.wdata = op_i.store ? store_word : '0;
    end

endmodule

`default_nettype wire

// File: src/lsu_top.sv
/*
 * vector load/store unit
 * decode, request and write-back stages for unit-stride accesses
 */

`default_nettype none

module lsu_top (
    input  wire logic                   clk_i,
    input  wire logic                   async_rst_n,

    // operation interface
    input  wire logic                   op_rdy_i,
    input  wire logic                   op_store_i,
    input  wire lsu_op_pkg::eew_e       op_eew_i,
    input  wire lsu_cfg_pkg::vl_t       op_vl_i,
    input  wire lsu_cfg_pkg::vreg_idx_t op_vd_i,
    input  wire lsu_cfg_pkg::addr_t     op_base_i,
    output logic                        op_ack_o,
    output logic                        misaligned_o,

    // register file
    output lsu_cfg_pkg::vreg_idx_t      vreg_rd_addr_o,
    input  wire lsu_cfg_pkg::vreg_t     vreg_rd_i,
    output logic                        vreg_wr_en_o,
    output lsu_cfg_pkg::vreg_idx_t      vreg_wr_addr_o,
    output lsu_cfg_pkg::vreg_t          vreg_wr_o,
    output lsu_cfg_pkg::vreg_mask_t     vreg_wr_mask_o,

    // memory
    output logic                        data_req_o,
    output lsu_op_pkg::mem_req_t        data_o,
    input  wire logic                   data_gnt_i,
    input  wire logic                   data_rvalid_i,
    input  wire lsu_cfg_pkg::vmem_t     data_rdata_i,

    // status
    output logic                        pending_load_o,
    output logic                        pending_store_o
);

    import lsu_op_pkg::*;

    lsu_op_t op;
    logic    start;
    logic    req_busy;
    logic    wb_busy;

    lsu_decode u_decode (
        .clk_i        (clk_i),
        .async_rst_n  (async_rst_n),
        .op_rdy_i     (op_rdy_i),
        .op_store_i   (op_store_i),
        .op_eew_i     (op_eew_i),
        .op_vl_i      (op_vl_i),
        .op_vd_i      (op_vd_i),
        .op_base_i    (op_base_i),
        .op_ack_o     (op_ack_o),
        .misaligned_o (misaligned_o),
        .req_busy_i   (req_busy),
        .wb_busy_i    (wb_busy),
        .start_o      (start),
        .op_o         (op)
    );

    lsu_request u_request (
        .clk_i          (clk_i),
        .async_rst_n    (async_rst_n),
        .start_i        (start),
        .op_i           (op),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .vreg_rd_i      (vreg_rd_i),
        .data_req_o     (data_req_o),
        .data_o         (data_o),
        .data_gnt_i     (data_gnt_i),
        .req_busy_o     (req_busy)
    );

    lsu_writeback u_writeback (
        .clk_i          (clk_i),
        .async_rst_n    (async_rst_n),
        .start_i        (start),
        .op_i           (op),
        .data_rvalid_i  (data_rvalid_i),
        .data_rdata_i   (data_rdata_i),
        .vreg_wr_en_o   (vreg_wr_en_o),
        .vreg_wr_addr_o (vreg_wr_addr_o),
        .vreg_wr_o      (vreg_wr_o),
        .vreg_wr_mask_o (vreg_wr_mask_o),
        .wb_busy_o      (wb_busy)
    );

    // a load stays pending until its register write
    assign pending_store_o = req_busy & op.store;
    assign pending_load_o  = (req_busy | wb_busy) & ~op.store;

endmodule

`default_nettype wire

// File: src/lsu_writeback.sv
/*
 * load write-back stage
 * collects returned beats into a register and writes it with the tail mask
 */

`default_nettype none

module lsu_writeback (
    input  wire logic                   clk_i,
    input  wire logic                   async_rst_n,

    input  wire logic                   start_i,
    input  wire lsu_op_pkg::lsu_op_t    op_i,

    input  wire logic                   data_rvalid_i,
    input  wire lsu_cfg_pkg::vmem_t     data_rdata_i,

    output logic                        vreg_wr_en_o,
    output lsu_cfg_pkg::vreg_idx_t      vreg_wr_addr_o,
    output lsu_cfg_pkg::vreg_t          vreg_wr_o,
    output lsu_cfg_pkg::vreg_mask_t     vreg_wr_mask_o,

    output logic                        wb_busy_o
);

    import lsu_cfg_pkg::*;
    import lsu_op_pkg::*;

    logic      start_load;
    logic      active;
    logic      take;
    logic      beat_last;
    logic      armed_q;
    logic      wr_en_q;
    beat_cnt_t cnt_q;
    vreg_t     buf_q;

    // armed at start so read data may return while requests still go out
    assign start_load = start_i & ~op_i.store;
    assign active     = armed_q | start_load;
    assign take       = active & data_rvalid_i;
    assign beat_last  = (cnt_q == beat_cnt_t'(BEATS - 1));

    ////////////////////////////////////////////////////////////
    // beat counting

    always_ff @(posedge clk_i or negedge async_rst_n) begin
        if (!async_rst_n) begin
            armed_q <= 1'b0;
            wr_en_q <= 1'b0;
            cnt_q   <= '0;
        end else begin
            wr_en_q <= take & beat_last;
            if (take) begin
                cnt_q <= beat_last ? '0 : cnt_q + 1'b1;
            end
            if (take && beat_last) begin
                armed_q <= 1'b0;
            end else if (start_load) begin
                armed_q <= 1'b1;
            end
        end
    end

    // new beats enter at the top, first beat ends in the low bytes
    always_ff @(posedge clk_i) begin
        if (take) begin
            buf_q <= {data_rdata_i, buf_q[VREG_W-1:VMEM_W]};
        end
    end

    ////////////////////////////////////////////////////////////
    // register write

    assign vreg_wr_en_o   = wr_en_q;
    assign vreg_wr_addr_o = op_i.vd;
    assign vreg_wr_o      = buf_q;

    always_comb begin
        for (int i = 0; i < VREG_BYTES; i++) begin
            vreg_wr_mask_o[i] = byte_cnt_t'(i) < op_i.byte_cnt;
        end
    end

    // busy until the write itself has gone out
    assign wb_busy_o = start_load | armed_q | wr_en_q;

endmodule

`default_nettype wire

// File: vlog.f
src/lsu_cfg_pkg.sv
src/lsu_op_pkg.sv
src/lsu_decode.sv
src/lsu_request.sv
src/lsu_writeback.sv
src/lsu_top.sv
sim/lsu_assert.sv
sim/tb_clock_gen.sv
sim/tb_lsu.sv
